//--- hw/board_defines.svh
// Board-wide widths, address map, register offsets and reset timing, included by RTL and testbench
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// Pins on the GPIO header
`define CFG_GPIO_WIDTH 12

// Cycles both locks must hold before system reset is released
`define PRCI_LOCK_CYCLES 16

// APB bus widths
`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32

// Slot select sits just above the register offset
`define APB_OFFSET_WIDTH 12
`define APB_SLOT_WIDTH 4

// Slot values in address bits 15..12
`define APB_SLOT_PRCI 4'h0
`define APB_SLOT_GPIO 4'h1

// PRCI registers
`define PRCI_REG_STATUS 12'h000
`define PRCI_REG_SWRESET 12'h004

// GPIO registers
`define GPIO_REG_DIR 12'h000
`define GPIO_REG_OUT 12'h004
`define GPIO_REG_IN 12'h008

`endif

//--- hw/types_amba_pkg.sv
// APB request and response types shared by the external master, the multiplexer and every slave
`default_nettype none

`include "board_defines.svh"

package types_amba_pkg;

  // Plain bus vectors
  typedef logic [`APB_ADDR_WIDTH-1:0] apb_addr_t;
  typedef logic [`APB_DATA_WIDTH-1:0] apb_data_t;

  // Address fields seen by the decoder and the register blocks
  typedef logic [`APB_SLOT_WIDTH-1:0] apb_slot_t;
  typedef logic [`APB_OFFSET_WIDTH-1:0] apb_offset_t;

  // Master to slave
  typedef struct packed {
    apb_addr_t paddr;
    logic psel;
    logic penable;
    logic pwrite;
    apb_data_t pwdata;
  } apb_in_type;

  // Slave to master, prdata only meaningful with pready
  typedef struct packed {
    apb_data_t prdata;
    logic pready;
    logic pslverr;
  } apb_out_type;

endpackage : types_amba_pkg

`default_nettype wire

//--- hw/types_board_pkg.sv
// Board control types for the GPIO pins and the reset controller, used by RTL and testbench
`default_nettype none

`include "board_defines.svh"

package types_board_pkg;

  // One bit per GPIO pin
  typedef logic [`CFG_GPIO_WIDTH-1:0] gpio_word_t;

  // Reset sequencing states
  typedef enum logic [1:0] {
    PRCI_POWER_RESET = 2'd0,
    PRCI_WAIT_LOCK = 2'd1,
    PRCI_RUN = 2'd2
  } prci_state_t;

  // STATUS register layout, sys_locked lands in bit 0
  typedef struct packed {
    logic sys_rst;
    logic ddr_locked;
    logic sys_locked;
  } prci_status_t;

endpackage : types_board_pkg

`default_nettype wire

//--- hw/apb_slv_mux.sv
// Combinational APB decoder that steers the external master to the PRCI or GPIO slave by address
`timescale 1ns/10ps
`default_nettype none

`include "board_defines.svh"

module apb_slv_mux (
  input wire types_amba_pkg::apb_in_type i_apbi,
  output types_amba_pkg::apb_out_type o_apbo,
  output types_amba_pkg::apb_in_type o_prci_apbi,
  input wire types_amba_pkg::apb_out_type i_prci_apbo,
  output types_amba_pkg::apb_in_type o_gpio_apbi,
  input wire types_amba_pkg::apb_out_type i_gpio_apbo
);

  types_amba_pkg::apb_slot_t slot;
  logic access;

  // Slot field sits right above the register offset
  assign slot = i_apbi.paddr[`APB_OFFSET_WIDTH +: `APB_SLOT_WIDTH];
  assign access = i_apbi.psel & i_apbi.penable;

  // Request side, only the chosen slave sees psel
  always_comb begin
    o_prci_apbi = i_apbi;
    o_gpio_apbi = i_apbi;
    o_prci_apbi.psel = i_apbi.psel & (slot == `APB_SLOT_PRCI);
    o_gpio_apbi.psel = i_apbi.psel & (slot == `APB_SLOT_GPIO);
  end

  // Response side
  always_comb begin
    case (slot)
      `APB_SLOT_PRCI: begin
        o_apbo = i_prci_apbo;
      end
      `APB_SLOT_GPIO: begin
        o_apbo = i_gpio_apbo;
      end
      default: begin
        // Unmapped slot completes at once with an error
        o_apbo.prdata = '0;
        o_apbo.pready = access;
        o_apbo.pslverr = access;
      end
    endcase
  end

endmodule : apb_slv_mux

`default_nettype wire

//--- hw/apb_prci.sv
// Reset controller that holds system reset until both locks are stable, with an APB status port
`timescale 1ns/10ps
`default_nettype none

`include "board_defines.svh"

module apb_prci (
  input wire i_clk,
  input wire i_reset,
  input wire i_dmireset,
  input wire i_sys_locked,
  input wire i_ddr_locked,
  output logic o_sys_rst,
  output logic o_dbg_rst,
  input wire types_amba_pkg::apb_in_type i_apbi,
  output types_amba_pkg::apb_out_type o_apbo
);

  localparam int LOCK_CNT_W = $clog2(`PRCI_LOCK_CYCLES + 1);
  localparam int STATUS_W = $bits(types_board_pkg::prci_status_t);

  typedef logic [LOCK_CNT_W-1:0] lock_cnt_t;

  types_board_pkg::prci_state_t state;
  types_board_pkg::prci_status_t status;
  types_amba_pkg::apb_offset_t offset;
  lock_cnt_t lock_cnt;
  logic sys_rst_q;
  logic dbg_rst_q;
  logic access;
  logic sw_req;
  logic both_locked;
  logic force_rst;

  assign offset = i_apbi.paddr[`APB_OFFSET_WIDTH-1:0];
  assign access = i_apbi.psel & i_apbi.penable;

  // Software reset request lands on the edge ending the access cycle
  assign sw_req = access & i_apbi.pwrite & (offset == `PRCI_REG_SWRESET) & i_apbi.pwdata[0];

  assign both_locked = i_sys_locked & i_ddr_locked;
  assign force_rst = ~both_locked | i_dmireset | sw_req;

  // Debug reset just follows power-on reset by one edge
  always_ff @(posedge i_clk) begin
    dbg_rst_q <= i_reset;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= types_board_pkg::PRCI_POWER_RESET;
      lock_cnt <= '0;
      sys_rst_q <= 1'b1;
    end else begin
      case (state)
        types_board_pkg::PRCI_POWER_RESET: begin
          state <= types_board_pkg::PRCI_WAIT_LOCK;
          lock_cnt <= force_rst ? '0 : lock_cnt + lock_cnt_t'(1);
        end
        types_board_pkg::PRCI_WAIT_LOCK: begin
          // Any glitch on the locks restarts the hold time
          if (force_rst) begin
            lock_cnt <= '0;
          end else if (lock_cnt == lock_cnt_t'(`PRCI_LOCK_CYCLES)) begin
            state <= types_board_pkg::PRCI_RUN;
            sys_rst_q <= 1'b0;
          end else begin
            lock_cnt <= lock_cnt + lock_cnt_t'(1);
          end
        end
        types_board_pkg::PRCI_RUN: begin
          if (force_rst) begin
            state <= types_board_pkg::PRCI_WAIT_LOCK;
            lock_cnt <= '0;
            sys_rst_q <= 1'b1;
          end
        end
        default: begin
          state <= types_board_pkg::PRCI_POWER_RESET;
          lock_cnt <= '0;
          sys_rst_q <= 1'b1;
        end
      endcase
    end
  end

  // Live lock inputs plus the current reset output
  always_comb begin
    status.sys_locked = i_sys_locked;
    status.ddr_locked = i_ddr_locked;
    status.sys_rst = sys_rst_q;
  end

  // Zero wait states, unknown offsets read zero without error
  always_comb begin
    o_apbo = '0;
    o_apbo.pready = access;
    if (access && !i_apbi.pwrite && (offset == `PRCI_REG_STATUS)) begin
      o_apbo.prdata[STATUS_W-1:0] = status;
    end
  end

  assign o_sys_rst = sys_rst_q;
  assign o_dbg_rst = dbg_rst_q;

endmodule : apb_prci

`default_nettype wire

//--- hw/apb_gpio.sv
// GPIO controller with direction, output and synchronized input registers on an APB slave port
`timescale 1ns/10ps
`default_nettype none

`include "board_defines.svh"

module apb_gpio (
  input wire i_clk,
  input wire i_reset,
  input wire types_board_pkg::gpio_word_t i_gpio,
  output types_board_pkg::gpio_word_t o_gpio,
  output types_board_pkg::gpio_word_t o_gpio_oe,
  input wire types_amba_pkg::apb_in_type i_apbi,
  output types_amba_pkg::apb_out_type o_apbo
);

  types_board_pkg::gpio_word_t dir_q;
  types_board_pkg::gpio_word_t out_q;
  types_board_pkg::gpio_word_t sync_q;
  types_board_pkg::gpio_word_t in_q;
  types_board_pkg::gpio_word_t wr_word;
  types_amba_pkg::apb_offset_t offset;
  logic access;
  logic wr_en;

  assign offset = i_apbi.paddr[`APB_OFFSET_WIDTH-1:0];
  assign access = i_apbi.psel & i_apbi.penable;
  assign wr_en = access & i_apbi.pwrite;
  assign wr_word = i_apbi.pwdata[`CFG_GPIO_WIDTH-1:0];

  // Pin drive registers, held clear while the system is in reset
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (wr_en) begin
      if (offset == `GPIO_REG_DIR) begin
        dir_q <= wr_word;
      end
      if (offset == `GPIO_REG_OUT) begin
        out_q <= wr_word;
      end
    end
  end

  // Two flops against metastability on the pads
  always_ff @(posedge i_clk) begin
    sync_q <= i_gpio;
    in_q <= sync_q;
  end

  always_comb begin
    o_apbo = '0;
    o_apbo.pready = access;
    if (access && !i_apbi.pwrite) begin
      case (offset)
        `GPIO_REG_DIR: o_apbo.prdata[`CFG_GPIO_WIDTH-1:0] = dir_q;
        `GPIO_REG_OUT: o_apbo.prdata[`CFG_GPIO_WIDTH-1:0] = out_q;
        `GPIO_REG_IN: o_apbo.prdata[`CFG_GPIO_WIDTH-1:0] = in_q;
        default: o_apbo.prdata = '0;
      endcase
    end
  end

  // A set DIR bit enables the output buffer
  assign o_gpio_oe = dir_q;
  assign o_gpio = out_q;

endmodule : apb_gpio

`default_nettype wire

//--- hw/board_top.sv
// Board control top level joining the APB decoder, the reset controller and the GPIO block
`timescale 1ns/10ps
`default_nettype none

module board_top (
  input wire i_clk,
  input wire i_reset,
  input wire i_dmireset,
  input wire i_sys_locked,
  input wire i_ddr_locked,
  input wire types_amba_pkg::apb_in_type i_apbi,
  output types_amba_pkg::apb_out_type o_apbo,
  input wire types_board_pkg::gpio_word_t i_gpio,
  output types_board_pkg::gpio_word_t o_gpio,
  output types_board_pkg::gpio_word_t o_gpio_oe,
  output logic o_sys_rst,
  output logic o_dbg_rst
);

  // Per-slave APB links
  types_amba_pkg::apb_in_type prci_apbi;
  types_amba_pkg::apb_out_type prci_apbo;
  types_amba_pkg::apb_in_type gpio_apbi;
  types_amba_pkg::apb_out_type gpio_apbo;

  apb_slv_mux i_apb_slv_mux (
    .i_apbi(i_apbi),
    .o_apbo(o_apbo),
    .o_prci_apbi(prci_apbi),
    .i_prci_apbo(prci_apbo),
    .o_gpio_apbi(gpio_apbi),
    .i_gpio_apbo(gpio_apbo)
  );

  // Lock pins stand in for the PLL and DDR calibration status
  apb_prci i_apb_prci (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_dmireset(i_dmireset),
    .i_sys_locked(i_sys_locked),
    .i_ddr_locked(i_ddr_locked),
    .o_sys_rst(o_sys_rst),
    .o_dbg_rst(o_dbg_rst),
    .i_apbi(prci_apbi),
    .o_apbo(prci_apbo)
  );

  // GPIO lives in the system reset domain
  apb_gpio i_apb_gpio (
    .i_clk(i_clk),
    .i_reset(o_sys_rst),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_oe(o_gpio_oe),
    .i_apbi(gpio_apbi),
    .o_apbo(gpio_apbo)
  );

endmodule : board_top

`default_nettype wire

//--- testbench/tb_board_top.sv
// Table-driven testbench for board_top covering reset sequencing, GPIO and APB decode, built via all.f
`timescale 1ns/10ps
`default_nettype none

`include "board_defines.svh"

module tb_board_top;

  localparam int MAX_TESTS = 48;
  localparam int APB_TIMEOUT = 8;
  localparam int RST_TIMEOUT = `PRCI_LOCK_CYCLES + 3;
  localparam int GW = `CFG_GPIO_WIDTH;

  // Table operations
  localparam int OP_WRITE = 0;
  localparam int OP_READ = 1;
  localparam int OP_PINS = 2;
  localparam int OP_LOCKS = 3;
  localparam int OP_DMI = 4;
  localparam int OP_WAIT_RST = 5;
  localparam int OP_HOLD_RST = 6;
  localparam int OP_CHK_PINS = 7;
  localparam int OP_CHK_DBG = 8;

  // Register addresses with the slot in bits 15..12
  localparam logic [31:0] PRCI_STATUS_A = {16'h0000, `APB_SLOT_PRCI, `PRCI_REG_STATUS};
  localparam logic [31:0] PRCI_SWRESET_A = {16'h0000, `APB_SLOT_PRCI, `PRCI_REG_SWRESET};
  localparam logic [31:0] GPIO_DIR_A = {16'h0000, `APB_SLOT_GPIO, `GPIO_REG_DIR};
  localparam logic [31:0] GPIO_OUT_A = {16'h0000, `APB_SLOT_GPIO, `GPIO_REG_OUT};
  localparam logic [31:0] GPIO_IN_A = {16'h0000, `APB_SLOT_GPIO, `GPIO_REG_IN};
  localparam logic [31:0] UNMAPPED_A = {16'h0000, 4'h2, 12'h000};

  logic clk = 1'b0;
  logic reset;
  logic dmireset;
  logic sys_locked;
  logic ddr_locked;
  types_amba_pkg::apb_in_type apbi;
  types_amba_pkg::apb_out_type apbo;
  types_board_pkg::gpio_word_t gpio_in;
  types_board_pkg::gpio_word_t gpio_out;
  types_board_pkg::gpio_word_t gpio_oe;
  logic sys_rst;
  logic dbg_rst;

  // One row of stimulus and expected values per test
  string test_name [MAX_TESTS];
  int test_op [MAX_TESTS];
  logic [31:0] test_addr [MAX_TESTS];
  logic [31:0] test_wdata [MAX_TESTS];
  logic [31:0] test_exp [MAX_TESTS];
  logic test_err [MAX_TESTS];
  int n_tests;
  int pass_count;
  int fail_count;
  logic [31:0] seed;

  always #2 clk = ~clk;

  board_top i_board_top (
    .i_clk(clk),
    .i_reset(reset),
    .i_dmireset(dmireset),
    .i_sys_locked(sys_locked),
    .i_ddr_locked(ddr_locked),
    .i_apbi(apbi),
    .o_apbo(apbo),
    .i_gpio(gpio_in),
    .o_gpio(gpio_out),
    .o_gpio_oe(gpio_oe),
    .o_sys_rst(sys_rst),
    .o_dbg_rst(dbg_rst)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // sys_locked in bit 0, ddr_locked in bit 1, sys_rst in bit 2
  function automatic logic [31:0] status_word(input logic rst, input logic ddr, input logic sys);
    return {29'd0, rst, ddr, sys};
  endfunction

  // Expected {oe, out} pin word
  function automatic logic [31:0] pins_word(input logic [31:0] oe, input logic [31:0] out);
    return {{(32 - 2 * GW){1'b0}}, oe[GW-1:0], out[GW-1:0]};
  endfunction

  function automatic logic [31:0] low_bits(input logic [31:0] value);
    return {{(32 - GW){1'b0}}, value[GW-1:0]};
  endfunction

  task automatic add_test(input string name, input int op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] exp, input logic err);
    test_name[n_tests] = name;
    test_op[n_tests] = op;
    test_addr[n_tests] = addr;
    test_wdata[n_tests] = wdata;
    test_exp[n_tests] = exp;
    test_err[n_tests] = err;
    n_tests++;
  endtask

  task automatic build_table();
    logic [31:0] dir_val;
    logic [31:0] out_val;
    logic [31:0] pin_a;
    logic [31:0] pin_b;
    seed = lcg_next(seed);
    dir_val = seed;
    seed = lcg_next(seed);
    out_val = seed;
    seed = lcg_next(seed);
    pin_a = seed;
    seed = lcg_next(seed);
    pin_b = seed;
    // Debug reset drops one edge after power-on reset
    add_test("dbg_rst_held", OP_CHK_DBG, 32'd0, 32'd0, 32'd1, 1'b0);
    add_test("dbg_rst_release", OP_CHK_DBG, 32'd0, 32'd0, 32'd0, 1'b0);
    add_test("rst_held_no_lock", OP_HOLD_RST, 32'd24, 32'd0, 32'd1, 1'b0);
    add_test("dir_in_reset", OP_READ, GPIO_DIR_A, 32'd0, 32'd0, 1'b0);
    add_test("locks_rise", OP_LOCKS, 32'd0, 32'd3, 32'd0, 1'b0);
    add_test("rst_release", OP_WAIT_RST, 32'd0, 32'd0, 32'd0, 1'b0);
    add_test("status_run", OP_READ, PRCI_STATUS_A, 32'd0,
             status_word(1'b0, 1'b1, 1'b1), 1'b0);
    add_test("dir_write", OP_WRITE, GPIO_DIR_A, dir_val, 32'd0, 1'b0);
    add_test("out_write", OP_WRITE, GPIO_OUT_A, out_val, 32'd0, 1'b0);
    add_test("pins_driven", OP_CHK_PINS, 32'd0, 32'd0, pins_word(dir_val, out_val), 1'b0);
    add_test("dir_readback", OP_READ, GPIO_DIR_A, 32'd0, low_bits(dir_val), 1'b0);
    add_test("out_readback", OP_READ, GPIO_OUT_A, 32'd0, low_bits(out_val), 1'b0);
    add_test("pins_in_a", OP_PINS, 32'd0, pin_a, 32'd0, 1'b0);
    add_test("in_read_a", OP_READ, GPIO_IN_A, 32'd0, low_bits(pin_a), 1'b0);
    add_test("pins_in_b", OP_PINS, 32'd0, pin_b, 32'd0, 1'b0);
    add_test("in_read_b", OP_READ, GPIO_IN_A, 32'd0, low_bits(pin_b), 1'b0);
    add_test("unmapped_read", OP_READ, UNMAPPED_A, 32'd0, 32'd0, 1'b1);
    add_test("unmapped_write", OP_WRITE, UNMAPPED_A + 32'd4, 32'hffff_ffff, 32'd0, 1'b1);
    add_test("swreset_write", OP_WRITE, PRCI_SWRESET_A, 32'd1, 32'd0, 1'b0);
    add_test("swreset_assert", OP_WAIT_RST, 32'd0, 32'd1, 32'd0, 1'b0);
    add_test("swreset_release", OP_WAIT_RST, 32'd0, 32'd0, 32'd0, 1'b0);
    add_test("dir_after_swreset", OP_READ, GPIO_DIR_A, 32'd0, 32'd0, 1'b0);
    add_test("out_after_swreset", OP_READ, GPIO_OUT_A, 32'd0, 32'd0, 1'b0);
    add_test("pins_after_swreset", OP_CHK_PINS, 32'd0, 32'd0, 32'd0, 1'b0);
    add_test("ddr_lock_drop", OP_LOCKS, 32'd0, 32'd1, 32'd0, 1'b0);
    add_test("lock_loss_assert", OP_WAIT_RST, 32'd0, 32'd1, 32'd0, 1'b0);
    add_test("status_lock_loss", OP_READ, PRCI_STATUS_A, 32'd0,
             status_word(1'b1, 1'b0, 1'b1), 1'b0);
    add_test("ddr_lock_restore", OP_LOCKS, 32'd0, 32'd3, 32'd0, 1'b0);
    add_test("lock_loss_release", OP_WAIT_RST, 32'd0, 32'd0, 32'd0, 1'b0);
    add_test("status_restored", OP_READ, PRCI_STATUS_A, 32'd0,
             status_word(1'b0, 1'b1, 1'b1), 1'b0);
    add_test("dmi_pulse", OP_DMI, 32'd0, 32'd0, 32'd0, 1'b0);
    add_test("dmi_assert", OP_WAIT_RST, 32'd0, 32'd1, 32'd0, 1'b0);
    add_test("status_dmi", OP_READ, PRCI_STATUS_A, 32'd0,
             status_word(1'b1, 1'b1, 1'b1), 1'b0);
    add_test("dmi_release", OP_WAIT_RST, 32'd0, 32'd0, 32'd0, 1'b0);
  endtask

  // Setup then access cycle with the response sampled mid-cycle
  task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err, output logic done);
    types_amba_pkg::apb_in_type req;
    int waits;
    req = '0;
    req.paddr = addr;
    req.psel = 1'b1;
    req.pwrite = wr;
    req.pwdata = wdata;
    rdata = '0;
    err = 1'b0;
    done = 1'b0;
    waits = 0;
    @(posedge clk);
    apbi <= req;
    @(posedge clk);
    req.penable = 1'b1;
    apbi <= req;
    while (!done && waits < APB_TIMEOUT) begin
      @(negedge clk);
      if (apbo.pready) begin
        done = 1'b1;
        rdata = apbo.prdata;
        err = apbo.pslverr;
      end
      @(posedge clk);
      waits++;
    end
    apbi <= '0;
  endtask

  task automatic wait_sys_rst(input logic level, output logic seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < RST_TIMEOUT) begin
      @(negedge clk);
      if (sys_rst === level) begin
        seen = 1'b1;
      end
      cycles++;
    end
  endtask

  task automatic run_test(input int idx, output logic ok);
    logic [31:0] rdata;
    logic err;
    logic done;
    int cycles;
    ok = 1'b1;
    case (test_op[idx])
      OP_WRITE, OP_READ: begin
        apb_transfer(test_op[idx] == OP_WRITE, test_addr[idx], test_wdata[idx], rdata, err,
                     done);
        if (!done) begin
          $display("%s: pready never arrived", test_name[idx]);
          ok = 1'b0;
        end else begin
          if (err !== test_err[idx]) begin
            $display("ERROR %s: expected pslverr %b, actual %b", test_name[idx],
                     test_err[idx], err);
            ok = 1'b0;
          end
          if (test_op[idx] == OP_READ && rdata !== test_exp[idx]) begin
            $display("ERROR %s: expected %h, actual %h", test_name[idx], test_exp[idx], rdata);
            ok = 1'b0;
          end
        end
      end
      OP_PINS: begin
        @(posedge clk);
        gpio_in <= test_wdata[idx][GW-1:0];
        // Two synchronizer stages plus margin
        repeat (4) @(posedge clk);
      end
      OP_LOCKS: begin
        @(posedge clk);
        sys_locked <= test_wdata[idx][0];
        ddr_locked <= test_wdata[idx][1];
      end
      OP_DMI: begin
        @(posedge clk);
        dmireset <= 1'b1;
        @(posedge clk);
        dmireset <= 1'b0;
      end
      OP_WAIT_RST: begin
        wait_sys_rst(test_wdata[idx][0], done);
        if (!done) begin
          $display("%s: o_sys_rst did not reach %b within %0d cycles", test_name[idx],
                   test_wdata[idx][0], RST_TIMEOUT);
          ok = 1'b0;
        end
      end
      OP_HOLD_RST: begin
        for (cycles = 0; cycles < int'(test_addr[idx]); cycles++) begin
          @(negedge clk);
          if (sys_rst !== test_exp[idx][0]) begin
            $display("ERROR %s: expected %b, actual %b", test_name[idx], test_exp[idx][0],
                     sys_rst);
            ok = 1'b0;
          end
        end
      end
      OP_CHK_PINS: begin
        @(negedge clk);
        if ({gpio_oe, gpio_out} !== test_exp[idx][2*GW-1:0]) begin
          $display("ERROR %s: expected %h, actual %h", test_name[idx],
                   test_exp[idx][2*GW-1:0], {gpio_oe, gpio_out});
          ok = 1'b0;
        end
      end
      OP_CHK_DBG: begin
        @(negedge clk);
        if (dbg_rst !== test_exp[idx][0]) begin
          $display("ERROR %s: expected %b, actual %b", test_name[idx], test_exp[idx][0],
                   dbg_rst);
          ok = 1'b0;
        end
      end
      default: begin
        $display("%s: unknown table operation %0d", test_name[idx], test_op[idx]);
        ok = 1'b0;
      end
    endcase
  endtask

  initial begin : main
    logic ok;
    reset = 1'b1;
    dmireset = 1'b0;
    sys_locked = 1'b0;
    ddr_locked = 1'b0;
    apbi = '0;
    gpio_in = '0;
    n_tests = 0;
    pass_count = 0;
    fail_count = 0;
    seed = 32'h6781da4d;
    build_table();
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int idx = 0; idx < n_tests; idx++) begin
      run_test(idx, ok);
      if (ok) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      $display("[%0d] %s %s", idx, test_name[idx], ok ? "passed" : "failed");
    end
    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_board_top

`default_nettype wire

//--- all.f
+incdir+hw
hw/types_amba_pkg.sv
hw/types_board_pkg.sv
hw/apb_slv_mux.sv
hw/apb_prci.sv
hw/apb_gpio.sv
hw/board_top.sv
testbench/tb_board_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the board_top testbench with Verilator, runs it and checks the log for the pass line
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
OBJ_DIR="$BUILD_DIR/obj"
LOG_FILE="$BUILD_DIR/sim.log"
PASS_MSG='All tests passed!'

mkdir -p "$OBJ_DIR"
status=$?
if [ $status -ne 0 ]; then
  echo "Could not create $OBJ_DIR"
  exit 1
fi

verilator --binary --timing -f all.f --top-module tb_board_top \
  -Mdir "$OBJ_DIR" -o Vtb_board_top
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"$OBJ_DIR/Vtb_board_top" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "$PASS_MSG" "$LOG_FILE"; then
  echo "Simulation PASSED"
  exit 0
else
  echo "Simulation FAILED, see $LOG_FILE"
  exit 1
fi
